/* logic/exu_alu.sv */
/*
 Integer ALU
 Add, subtract, logic, shift and compare with the X-stage result register
*/
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module exu_alu (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_data_en,   // X-stage enable, low stalls
   input  logic              i_valid,     // ALU instruction in D
   input  exu_pkg::alu_op_t  i_op,
   input  exu_pkg::word_t    i_a,
   input  exu_pkg::word_t    i_b,
   output exu_pkg::word_t    o_result     // Registered X-stage result
);
   import exu_pkg::*;

   logic [`EXU_SHAMT_W-1:0] shamt;
   logic                    lt_signed;
   logic                    lt_unsigned;
   word_t                   alu_d;

   assign shamt       = i_b[`EXU_SHAMT_W-1:0];
   assign lt_signed   = $signed(i_a) < $signed(i_b);
   assign lt_unsigned = i_a < i_b;

   always_comb begin
      case (i_op)
         ALU_ADD:  alu_d = i_a + i_b;
         ALU_SUB:  alu_d = i_a - i_b;
         ALU_AND:  alu_d = i_a & i_b;
         ALU_OR:   alu_d = i_a | i_b;
         ALU_XOR:  alu_d = i_a ^ i_b;
         ALU_SLL:  alu_d = i_a << shamt;
         ALU_SRL:  alu_d = i_a >> shamt;
         ALU_SRA:  alu_d = $signed(i_a) >>> shamt;   // Sign fill
         ALU_SLT:  alu_d = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
         ALU_SLTU: alu_d = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
         default:  alu_d = '0;                       // Unused encodings
      endcase
   end

   // Holds through stalls and non-ALU cycles
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_result <= '0;
      end else if (i_data_en && i_valid) begin
         o_result <= alu_d;
      end
   end

endmodule

`default_nettype wire

/* logic/exu_bypass_mux.sv */
/*
 Operand bypass mux
 AND-OR selection over the four forwarding sources, one-hot enables
*/
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module exu_bypass_mux (
   input  exu_pkg::byp_en_t i_byp_en,     // One-hot or zero
   input  exu_pkg::word_t   i_result_r,   // R-stage result
   input  exu_pkg::word_t   i_load_m,     // M-stage load result
   input  exu_pkg::word_t   i_result_x,   // X-stage result feedback
   input  exu_pkg::word_t   i_load_nb,    // Non-blocking load data
   output logic             o_hit,        // Any source selected
   output exu_pkg::word_t   o_data        // Forwarded data
);
   import exu_pkg::*;

   word_t data_r;
   word_t data_m;
   word_t data_x;
   word_t data_nb;

   assign data_r  = {`EXU_XLEN{i_byp_en[BYP_RESULT_R]}} & i_result_r;
   assign data_m  = {`EXU_XLEN{i_byp_en[BYP_LOAD_M]}}   & i_load_m;
   assign data_x  = {`EXU_XLEN{i_byp_en[BYP_RESULT_X]}} & i_result_x;
   assign data_nb = {`EXU_XLEN{i_byp_en[BYP_LOAD_NB]}}  & i_load_nb;

   assign o_hit  = |i_byp_en;
   assign o_data = data_r | data_m | data_x | data_nb;   // Enables never overlap

endmodule

`default_nettype wire

/* logic/exu_execute.sv */
/*
 X-stage execute
 ALU and multiplier side by side, result picked by the registered mul flag
*/
`timescale 1ns/100ps
`default_nettype none

module exu_execute (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_data_en,
   input  logic              i_alu_valid,
   input  exu_pkg::alu_op_t  i_alu_op,
   input  exu_pkg::word_t    i_rs1,
   input  exu_pkg::word_t    i_muldiv_rs1,
   input  exu_pkg::word_t    i_rs2,
   input  logic              i_mul_valid,
   input  logic              i_mul_rs1_sign,
   input  logic              i_mul_rs2_sign,
   input  logic              i_mul_low,
   output exu_pkg::word_t    o_result_x
);
   import exu_pkg::*;

   word_t alu_result_x;
   word_t mul_result_x;
   logic  mul_valid_x;   // Multiply occupies X

   exu_alu u_alu (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_data_en (i_data_en),
      .i_valid   (i_alu_valid),
      .i_op      (i_alu_op),
      .i_a       (i_rs1),
      .i_b       (i_rs2),
      .o_result  (alu_result_x)
   );

   exu_mul u_mul (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_valid    (i_mul_valid),
      .i_rs1_sign (i_mul_rs1_sign),
      .i_rs2_sign (i_mul_rs2_sign),
      .i_low      (i_mul_low),
      .i_a        (i_muldiv_rs1),
      .i_b        (i_rs2),
      .o_result   (mul_result_x)
   );

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         mul_valid_x <= 1'b0;
      end else begin
         mul_valid_x <= i_mul_valid;   // Not gated by the stall
      end
   end

   assign o_result_x = mul_valid_x ? mul_result_x : alu_result_x;

endmodule

`default_nettype wire

/* logic/exu_mul.sv */
/*
 Multiplier
 33x33 signed product of sign-extended operands, low or high word registered
*/
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module exu_mul (
   input  logic           clk,
   input  logic           i_rst_n,
   input  logic           i_valid,      // Multiply in D
   input  logic           i_rs1_sign,   // Treat rs1 as signed
   input  logic           i_rs2_sign,   // Treat rs2 as signed
   input  logic           i_low,        // Low word, else high word
   input  exu_pkg::word_t i_a,
   input  exu_pkg::word_t i_b,
   output exu_pkg::word_t o_result
);
   import exu_pkg::*;

   word_t                          a_q;
   word_t                          b_q;
   logic signed [`EXU_XLEN:0]      a_ext;
   logic signed [`EXU_XLEN:0]      b_ext;
   logic signed [2*`EXU_XLEN+1:0]  prod;

   // Quiet the array when no multiply is issued
   assign a_q = {`EXU_XLEN{i_valid}} & i_a;
   assign b_q = {`EXU_XLEN{i_valid}} & i_b;

   assign a_ext = {i_rs1_sign & a_q[`EXU_XLEN-1], a_q};
   assign b_ext = {i_rs2_sign & b_q[`EXU_XLEN-1], b_q};
   assign prod  = a_ext * b_ext;                          // 66-bit signed product

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_result <= '0;
      end else if (i_valid) begin
         o_result <= i_low ? prod[`EXU_XLEN-1:0] : prod[2*`EXU_XLEN-1:`EXU_XLEN];
      end
   end

endmodule

`default_nettype wire

/* logic/exu_params.svh */
/*
 Execute stage sizing
 Data and PC widths, bypass source count, opcode and shift widths
*/
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`define EXU_XLEN      32   // Data word width
`define EXU_PC_W      31   // PC bits 31:1, bit 0 implied zero

`define EXU_BYP_SRCS  4    // R result, M load, X result, non-blocking load

`define EXU_ALU_OP_W  4    // ALU opcode width
`define EXU_SHAMT_W   5    // Shift amount taken from low operand bits

`endif

/* logic/exu_pkg.sv */
/*
 Execute stage package
 Data, PC, bypass enable and ALU opcode types shared by the stage
*/
`default_nettype none

`include "exu_params.svh"

package exu_pkg;

   typedef logic [`EXU_XLEN-1:0]     word_t;     // One data word
   typedef logic [`EXU_PC_W:1]       pc_t;       // Instruction address 31:1
   typedef logic [`EXU_BYP_SRCS-1:0] byp_en_t;   // One-hot forwarding select

   // Bit positions inside byp_en_t
   localparam int unsigned BYP_RESULT_R = 0;     // R-stage result
   localparam int unsigned BYP_LOAD_M   = 1;     // M-stage load result
   localparam int unsigned BYP_RESULT_X = 2;     // X-stage result
   localparam int unsigned BYP_LOAD_NB  = 3;     // Non-blocking load data

   typedef enum logic [`EXU_ALU_OP_W-1:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
   } alu_op_t;

endpackage

`default_nettype wire

/* logic/exu_rs1_select.sv */
/*
 RS1 operand select
 Bypass, then PC for jal/auipc, then qualified GPR. Multiplier path skips PC
*/
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module exu_rs1_select (
   input  exu_pkg::byp_en_t i_byp_en,
   input  exu_pkg::word_t   i_result_r,
   input  exu_pkg::word_t   i_load_m,
   input  exu_pkg::word_t   i_result_x,
   input  exu_pkg::word_t   i_load_nb,
   input  exu_pkg::word_t   i_gpr,          // Register file read data
   input  logic             i_rs1_en,       // Qualifies GPR data
   input  logic             i_select_pc,    // PC replaces rs1
   input  exu_pkg::pc_t     i_pc,
   output exu_pkg::word_t   o_rs1,          // ALU operand
   output exu_pkg::word_t   o_muldiv_rs1    // Multiplier operand
);
   import exu_pkg::*;

   logic  byp_hit;
   word_t byp_data;
   word_t pc_word;

   exu_bypass_mux u_byp (
      .i_byp_en   (i_byp_en),
      .i_result_r (i_result_r),
      .i_load_m   (i_load_m),
      .i_result_x (i_result_x),
      .i_load_nb  (i_load_nb),
      .o_hit      (byp_hit),
      .o_data     (byp_data)
   );

   assign pc_word = {i_pc, 1'b0};   // Halfword aligned

   assign o_rs1 = ({`EXU_XLEN{byp_hit}}                             & byp_data) |
                  ({`EXU_XLEN{~byp_hit & i_select_pc}}              & pc_word)  |
                  ({`EXU_XLEN{~byp_hit & ~i_select_pc & i_rs1_en}}  & i_gpr);

   assign o_muldiv_rs1 = ({`EXU_XLEN{byp_hit}}             & byp_data) |
                         ({`EXU_XLEN{~byp_hit & i_rs1_en}} & i_gpr);

endmodule

`default_nettype wire

/* logic/exu_rs2_select.sv */
/*
 RS2 operand select
 Bypass data, or qualified GPR ORed with the decoder immediate
*/
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module exu_rs2_select (
   input  exu_pkg::byp_en_t i_byp_en,
   input  exu_pkg::word_t   i_result_r,
   input  exu_pkg::word_t   i_load_m,
   input  exu_pkg::word_t   i_result_x,
   input  exu_pkg::word_t   i_load_nb,
   input  exu_pkg::word_t   i_gpr,       // Register file read data
   input  exu_pkg::word_t   i_immed,     // Zero when not an immediate op
   input  logic             i_rs2_en,    // Qualifies GPR data
   output exu_pkg::word_t   o_rs2
);
   import exu_pkg::*;

   logic  byp_hit;
   word_t byp_data;

   exu_bypass_mux u_byp (
      .i_byp_en   (i_byp_en),
      .i_result_r (i_result_r),
      .i_load_m   (i_load_m),
      .i_result_x (i_result_x),
      .i_load_nb  (i_load_nb),
      .o_hit      (byp_hit),
      .o_data     (byp_data)
   );

   assign o_rs2 = ({`EXU_XLEN{byp_hit}}             & byp_data) |
                  ({`EXU_XLEN{~byp_hit & i_rs2_en}} & i_gpr)    |
                  ({`EXU_XLEN{~byp_hit}}            & i_immed);

endmodule

`default_nettype wire

/* logic/exu_top.sv */
/*
 Integer execute stage top
 Operand selectors in D feeding the X-stage ALU and multiplier
*/
`timescale 1ns/100ps
`default_nettype none

module exu_top (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_data_en,        // X-stage enable
   input  exu_pkg::byp_en_t  i_rs1_byp_en,
   input  exu_pkg::byp_en_t  i_rs2_byp_en,
   input  exu_pkg::word_t    i_result_r,       // R-stage result
   input  exu_pkg::word_t    i_load_m,         // M-stage load result
   input  exu_pkg::word_t    i_load_nb,        // Non-blocking load data
   input  exu_pkg::word_t    i_gpr_rs1,
   input  exu_pkg::word_t    i_gpr_rs2,
   input  exu_pkg::word_t    i_immed,
   input  logic              i_rs1_en,
   input  logic              i_rs2_en,
   input  logic              i_select_pc,
   input  exu_pkg::pc_t      i_pc,
   input  logic              i_alu_valid,
   input  exu_pkg::alu_op_t  i_alu_op,
   input  logic              i_mul_valid,
   input  logic              i_mul_rs1_sign,
   input  logic              i_mul_rs2_sign,
   input  logic              i_mul_low,
   output exu_pkg::word_t    o_result_x        // Also fed back for bypass
);
   import exu_pkg::*;

   word_t rs1_d;
   word_t muldiv_rs1_d;
   word_t rs2_d;

   exu_rs1_select u_rs1_sel (
      .i_byp_en     (i_rs1_byp_en),
      .i_result_r   (i_result_r),
      .i_load_m     (i_load_m),
      .i_result_x   (o_result_x),
      .i_load_nb    (i_load_nb),
      .i_gpr        (i_gpr_rs1),
      .i_rs1_en     (i_rs1_en),
      .i_select_pc  (i_select_pc),
      .i_pc         (i_pc),
      .o_rs1        (rs1_d),
      .o_muldiv_rs1 (muldiv_rs1_d)
   );

   exu_rs2_select u_rs2_sel (
      .i_byp_en   (i_rs2_byp_en),
      .i_result_r (i_result_r),
      .i_load_m   (i_load_m),
      .i_result_x (o_result_x),
      .i_load_nb  (i_load_nb),
      .i_gpr      (i_gpr_rs2),
      .i_immed    (i_immed),
      .i_rs2_en   (i_rs2_en),
      .o_rs2      (rs2_d)
   );

   exu_execute u_exec (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_data_en      (i_data_en),
      .i_alu_valid    (i_alu_valid),
      .i_alu_op       (i_alu_op),
      .i_rs1          (rs1_d),
      .i_muldiv_rs1   (muldiv_rs1_d),
      .i_rs2          (rs2_d),
      .i_mul_valid    (i_mul_valid),
      .i_mul_rs1_sign (i_mul_rs1_sign),
      .i_mul_rs2_sign (i_mul_rs2_sign),
      .i_mul_low      (i_mul_low),
      .o_result_x     (o_result_x)
   );

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
+incdir+testbench
logic/exu_pkg.sv
logic/exu_bypass_mux.sv
logic/exu_rs1_select.sv
logic/exu_rs2_select.sv
logic/exu_alu.sv
logic/exu_mul.sv
logic/exu_execute.sv
logic/exu_top.sv
testbench/tb_exu.sv

/* testbench/exu_model.svh */
/*
 Execute stage reference model
 Operand rules, ALU operations and multiply halves for the testbench
*/
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

// Data of the single enabled source, zero when none
function automatic word_t forward_data(input byp_en_t en, input word_t r, m, x, nb);
   if (en[0]) return r;
   if (en[1]) return m;
   if (en[2]) return x;
   if (en[3]) return nb;
   return '0;
endfunction

// use_pc low gives the multiplier operand
function automatic word_t rs1_operand(input byp_en_t en, input word_t r, m, x, nb, gpr,
                                      input logic rs1_en, sel_pc, input pc_t pc,
                                      input logic use_pc);
   if (en != '0) return forward_data(en, r, m, x, nb);
   if (use_pc && sel_pc) return {pc, 1'b0};
   if (rs1_en) return gpr;
   return '0;
endfunction

function automatic word_t rs2_operand(input byp_en_t en, input word_t r, m, x, nb, gpr,
                                      input word_t imm, input logic rs2_en);
   if (en != '0) return forward_data(en, r, m, x, nb);
   return (rs2_en ? gpr : '0) | imm;
endfunction

function automatic word_t alu_result(input alu_op_t op, input word_t a, b);
   int unsigned sh;
   sh = b[`EXU_SHAMT_W-1:0];
   case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return $signed(a) >>> sh;
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:  return '0;
   endcase
endfunction

// 64-bit product is exact for bits 63:0 of the extended product
function automatic word_t mul_result(input word_t a, b, input logic s1, s2, low);
   longint sa;
   longint sb;
   longint p;
   sa = s1 ? longint'($signed(a)) : longint'(a);
   sb = s2 ? longint'($signed(b)) : longint'(b);
   p  = sa * sb;
   return low ? p[31:0] : p[63:32];
endfunction

`endif

/* testbench/tb_exu.sv */
/*
 Execute stage testbench
 Random operand, ALU, multiply and stall traffic checked against a model
*/
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module tb_exu;
   import exu_pkg::*;

   `include "exu_model.svh"

   localparam int MAX_CYCLES = 2000;   // Six tests of about 200 cycles plus margin
   localparam int TEST_LEN   = 200;

   logic    clk;
   logic    rst_n;
   logic    data_en;
   byp_en_t rs1_byp_en;
   byp_en_t rs2_byp_en;
   word_t   result_r;
   word_t   load_m;
   word_t   load_nb;
   word_t   gpr_rs1;
   word_t   gpr_rs2;
   word_t   immed;
   logic    rs1_en;
   logic    rs2_en;
   logic    select_pc;
   pc_t     pc;
   logic    alu_valid;
   alu_op_t alu_op;
   logic    mul_valid;
   logic    mul_rs1_sign;
   logic    mul_rs2_sign;
   logic    mul_low;
   word_t   result_x;

   word_t   alu_q;           // Model ALU register
   word_t   mul_q;           // Model multiplier register
   logic    mul_sel_q;       // Model mul-select flag
   integer  seed;
   int      cycles      = 0;
   int      checks      = 0;
   int      errors      = 0;
   int      test_errors = 0;
   int      stall_left  = 0;

   exu_top u_dut (
      .clk            (clk),
      .i_rst_n        (rst_n),
      .i_data_en      (data_en),
      .i_rs1_byp_en   (rs1_byp_en),
      .i_rs2_byp_en   (rs2_byp_en),
      .i_result_r     (result_r),
      .i_load_m       (load_m),
      .i_load_nb      (load_nb),
      .i_gpr_rs1      (gpr_rs1),
      .i_gpr_rs2      (gpr_rs2),
      .i_immed        (immed),
      .i_rs1_en       (rs1_en),
      .i_rs2_en       (rs2_en),
      .i_select_pc    (select_pc),
      .i_pc           (pc),
      .i_alu_valid    (alu_valid),
      .i_alu_op       (alu_op),
      .i_mul_valid    (mul_valid),
      .i_mul_rs1_sign (mul_rs1_sign),
      .i_mul_rs2_sign (mul_rs2_sign),
      .i_mul_low      (mul_low),
      .o_result_x     (result_x)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   function automatic int rnd(input int n);
      return {$random(seed)} % n;
   endfunction

   // Test 4 always forwards, tests 5 and 6 half the time
   function automatic byp_en_t pick_byp(input int test);
      if (test == 4 || (test >= 5 && rnd(2) == 1)) begin
         return byp_en_t'(1 << rnd(`EXU_BYP_SRCS));
      end
      return '0;
   endfunction

   task automatic init_inputs();
      rst_n        <= 1'b0;
      data_en      <= 1'b0;
      rs1_byp_en   <= '0;
      rs2_byp_en   <= '0;
      result_r     <= '0;
      load_m       <= '0;
      load_nb      <= '0;
      gpr_rs1      <= '0;
      gpr_rs2      <= '0;
      immed        <= '0;
      rs1_en       <= 1'b0;
      rs2_en       <= 1'b0;
      select_pc    <= 1'b0;
      pc           <= '0;
      alu_valid    <= 1'b0;
      alu_op       <= ALU_ADD;
      mul_valid    <= 1'b0;
      mul_rs1_sign <= 1'b0;
      mul_rs2_sign <= 1'b0;
      mul_low      <= 1'b0;
      alu_q        = '0;
      mul_q        = '0;
      mul_sel_q    = 1'b0;
   endtask

   // Compare the X result, then advance the model by the inputs now in D
   task automatic check_cycle(input int test);
      word_t cur_x;
      word_t exp_x;
      word_t a;
      word_t ma;
      word_t b;
      cur_x = mul_sel_q ? mul_q : alu_q;
      exp_x = (test == 1) ? '0 : cur_x;
      checks++;
      if (result_x !== exp_x) begin
         errors++;
         test_errors++;
         $display("Mismatch o_result_x: got %h expected %h in test %0d", result_x, exp_x, test);
      end
      a  = rs1_operand(rs1_byp_en, result_r, load_m, cur_x, load_nb, gpr_rs1,
                       rs1_en, select_pc, pc, 1'b1);
      ma = rs1_operand(rs1_byp_en, result_r, load_m, cur_x, load_nb, gpr_rs1,
                       rs1_en, select_pc, pc, 1'b0);
      b  = rs2_operand(rs2_byp_en, result_r, load_m, cur_x, load_nb, gpr_rs2, immed, rs2_en);
      if (data_en && alu_valid) begin
         alu_q = alu_result(alu_op, a, b);
      end
      if (mul_valid) begin
         mul_q = mul_result(ma, b, mul_rs1_sign, mul_rs2_sign, mul_low);
      end
      mul_sel_q = mul_valid;
   endtask

   task automatic issue(input int test);
      logic is_mul;
      @(posedge clk);
      is_mul = (test == 5) || (test == 6 && rnd(3) == 0);
      if (test == 6 && stall_left == 0 && rnd(6) == 0) begin
         stall_left = 1 + rnd(5);   // Stall run length
      end
      data_en      <= (stall_left == 0);
      if (stall_left > 0) begin
         stall_left--;
      end
      rs1_byp_en   <= pick_byp(test);
      rs2_byp_en   <= pick_byp(test);
      result_r     <= $random(seed);
      load_m       <= $random(seed);
      load_nb      <= $random(seed);
      gpr_rs1      <= $random(seed);
      gpr_rs2      <= $random(seed);
      immed        <= (test == 3 || test == 6) ? word_t'($random(seed)) : '0;
      rs1_en       <= (rnd(2) == 1);
      rs2_en       <= (rnd(2) == 1);
      select_pc    <= (test >= 3) && (rnd(2) == 1);
      pc           <= pc_t'($random(seed));
      alu_valid    <= !is_mul && test != 1 && (test != 6 || rnd(4) != 0);
      alu_op       <= alu_op_t'(rnd(10));
      mul_valid    <= is_mul;
      mul_rs1_sign <= (rnd(2) == 1);
      mul_rs2_sign <= (rnd(2) == 1);
      mul_low      <= (rnd(2) == 1);
      @(negedge clk);
      check_cycle(test);
   endtask

   task automatic run_test(input int test, input string name, input int len);
      test_errors = 0;
      repeat (len) issue(test);
      $display("Test %0d %s: %0d cycles, %0d errors", test, name, len, test_errors);
   endtask

   initial begin
      seed = 32'hdaa8;
      init_inputs();
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      run_test(1, "reset", 10);
      run_test(2, "gpr operands", TEST_LEN);
      run_test(3, "pc and immediate", TEST_LEN);
      run_test(4, "bypass", TEST_LEN);
      run_test(5, "multiply", TEST_LEN);
      run_test(6, "stalls and interleaving", TEST_LEN);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
